// ==== Makefile ====
# Verilator flow for the keypad I2C block testbench
# compile builds the simulator, run executes it and checks the result

TOP = i2cTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// ==== busMapPkg.sv ====
// Register bus map for the keypad block
// Widths, base address and register offsets shared by the CSR and the testbench

package busMapPkg;

	//--------------------------------------------------------------------------
	// Bus widths
	//--------------------------------------------------------------------------
	localparam int busAdrsBits = 32;
	localparam int busDataBits = 32;

	//--------------------------------------------------------------------------
	// Block placement
	//--------------------------------------------------------------------------
	localparam int regOffBits = 8;	// Low address bits inside the block
	localparam logic [busAdrsBits-1:0] blockBase     = 32'h0000_0400;
	localparam logic [busAdrsBits-1:0] blockAdrsMask = 32'hFFFF_FF00;	// Upper 24 bits

	//--------------------------------------------------------------------------
	// Register offsets
	//--------------------------------------------------------------------------
	localparam logic [regOffBits-1:0] regCtrl   = 8'h00;	// Bit 0 enable
	localparam logic [regOffBits-1:0] regDiv    = 8'h04;	// SCL quarter divider
	localparam logic [regOffBits-1:0] regKeypad = 8'h08;	// Read only
	localparam logic [regOffBits-1:0] regStatus = 8'h0C;	// Read only

	// Status register layout
	localparam int statusCountBits = 8;	// Completed transactions, wraps
	localparam int statusBusyBit   = 8;	// Sequencer busy

endpackage

// ==== i2cBitEngine.sv ====
// Bit stage. Runs one command as four quarter periods of (divider + 1)
// clocks, drives SCL and open-drain SDA, and samples SDA in quarter three
`timescale 1ns/100ps

module i2cBitEngine (
	input  logic                       sysClk,
	input  logic                       rstN,
	input  logic [i2cPkg::divBits-1:0] divider,
	input  logic                       bitStart,
	input  logic [i2cPkg::cmdBits-1:0] bitCmd,
	input  logic                       bitWrite,
	output logic                       bitDone,
	output logic                       bitRead,
	output logic                       scl,
	inout  wire                        sda
);
	import i2cPkg::*;

	logic               active;
	logic [1:0]         phase;	// Quarter index
	logic [divBits-1:0] divCnt;
	logic [divBits-1:0] divLatch;	// Divider held for the whole command
	logic [cmdBits-1:0] cmdLatch;
	logic               wrLatch;
	logic               sdaRel;	// 1 releases the line
	logic               phaseEnd;

	assign sda      = sdaRel ? 1'bz : 1'b0;
	assign phaseEnd = active && (divCnt == divLatch);

	//--------------------------------------------------------------------------
	// Pin levels per quarter, returned as {scl, sda}
	//--------------------------------------------------------------------------
	function automatic logic [1:0] pinLevels(input logic [cmdBits-1:0] cmd,
		input logic wr, input logic [1:0] ph);
		logic dataBit;
		dataBit = (cmd == cmdRead) ? 1'b1 : wr;
		case (cmd)
			cmdStart:	// SDA falls with SCL high
				pinLevels = (ph == 2'd0) ? 2'b11 : (ph == 2'd3) ? 2'b00 : 2'b10;
			cmdStop:	// SDA rises with SCL high
				pinLevels = (ph == 2'd0) ? 2'b00 : (ph == 2'd1) ? 2'b10 : 2'b11;
			default:	// Data moves only while SCL is low
				pinLevels = {(ph == 2'd1 || ph == 2'd2), dataBit};
		endcase
	endfunction

	//--------------------------------------------------------------------------
	// Phase timing and pins
	//--------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			active  <= 1'b0;
			phase   <= 2'd0;
			divCnt  <= '0;
			bitDone <= 1'b0;
			scl     <= 1'b1;	// Bus idle
			sdaRel  <= 1'b1;
		end
		else
		begin
			bitDone <= 1'b0;
			if (!active)
			begin
				if (bitStart)
				begin
					active          <= 1'b1;
					phase           <= 2'd0;
					divCnt          <= '0;
					{scl, sdaRel}   <= pinLevels(bitCmd, bitWrite, 2'd0);
				end
			end
			else if (phaseEnd)
			begin
				divCnt <= '0;
				if (phase == 2'd3)
				begin
					active  <= 1'b0;	// Pins hold the last quarter
					bitDone <= 1'b1;
				end
				else
				begin
					phase         <= phase + 2'd1;
					{scl, sdaRel} <= pinLevels(cmdLatch, wrLatch, phase + 2'd1);
				end
			end
			else
				divCnt <= divCnt + 1'b1;
		end
	end

	// Command latch and SDA sample
	always_ff @(posedge sysClk)
	begin
		if (bitStart && !active)
		begin
			divLatch <= divider;
			cmdLatch <= bitCmd;
			wrLatch  <= bitWrite;
		end
		if (phaseEnd && phase == 2'd1)
			bitRead <= sda;	// Entering quarter three, SCL high
	end

endmodule

// ==== i2cBlock.sv ====
// Keypad I2C block top. Joins the register stage, transaction sequencer
// and bit engine between the register bus and the I2C pins
`timescale 1ns/100ps

module i2cBlock (
	input  logic                              sysClk,
	input  logic                              rstN,
	// Bus write side
	input  logic                              writeEnable,
	input  logic [busMapPkg::busAdrsBits-1:0] writeAdrs,
	input  logic [busMapPkg::busDataBits-1:0] writeData,
	// Bus read side
	input  logic                              readEnable,
	input  logic [busMapPkg::busAdrsBits-1:0] readAdrs,
	output logic [busMapPkg::busDataBits-1:0] readData,
	output logic                              readValid,
	// I2C pins
	output logic                              scl,
	inout  wire                               sda
);
	import i2cPkg::*;

	//--------------------------------------------------------------------------
	// CSR to sequencer
	//--------------------------------------------------------------------------
	logic               enable;
	logic [divBits-1:0] divider;
	logic [keyBits-1:0] keyWord;
	logic               seqDone;
	logic               busy;

	// Sequencer to bit engine
	logic               bitStart;
	logic [cmdBits-1:0] bitCmd;
	logic               bitWrite;
	logic               bitDone;
	logic               bitRead;

	i2cCsr i2cCsr_inst (
		.sysClk      (sysClk),
		.rstN        (rstN),
		.writeEnable (writeEnable),
		.writeAdrs   (writeAdrs),
		.writeData   (writeData),
		.readEnable  (readEnable),
		.readAdrs    (readAdrs),
		.readData    (readData),
		.readValid   (readValid),
		.keyWord     (keyWord),
		.seqDone     (seqDone),
		.busy        (busy),
		.enable      (enable),
		.divider     (divider)
	);

	i2cSequencer i2cSequencer_inst (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.enable   (enable),
		.bitDone  (bitDone),
		.bitRead  (bitRead),
		.bitStart (bitStart),
		.bitCmd   (bitCmd),
		.bitWrite (bitWrite),
		.keyWord  (keyWord),
		.seqDone  (seqDone),
		.busy     (busy)
	);

	i2cBitEngine i2cBitEngine_inst (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.divider  (divider),
		.bitStart (bitStart),
		.bitCmd   (bitCmd),
		.bitWrite (bitWrite),
		.bitDone  (bitDone),
		.bitRead  (bitRead),
		.scl      (scl),
		.sda      (sda)
	);

endmodule

// ==== i2cCsr.sv ====
// Register stage of the keypad block. Decodes bus strobes, holds control
// and divider, and latches the key word and count on each finished poll
`timescale 1ns/100ps

module i2cCsr (
	input  logic                              sysClk,
	input  logic                              rstN,
	input  logic                              writeEnable,
	input  logic [busMapPkg::busAdrsBits-1:0] writeAdrs,
	input  logic [busMapPkg::busDataBits-1:0] writeData,
	input  logic                              readEnable,
	input  logic [busMapPkg::busAdrsBits-1:0] readAdrs,
	output logic [busMapPkg::busDataBits-1:0] readData,
	output logic                              readValid,
	input  logic [i2cPkg::keyBits-1:0]        keyWord,
	input  logic                              seqDone,
	input  logic                              busy,
	output logic                              enable,
	output logic [i2cPkg::divBits-1:0]        divider
);
	import busMapPkg::*;
	import i2cPkg::*;

	logic                       writeHit;
	logic                       readHit;
	logic [keyBits-1:0]         keypadReg;	// Last completed key word
	logic [statusCountBits-1:0] doneCount;
	logic [busDataBits-1:0]     statusWord;

	//--------------------------------------------------------------------------
	// Address decode
	//--------------------------------------------------------------------------
	assign writeHit = writeEnable && ((writeAdrs & blockAdrsMask) == blockBase);
	assign readHit  = readEnable && ((readAdrs & blockAdrsMask) == blockBase);

	// Count in the low byte, busy above it
	always_comb
	begin
		statusWord                            = '0;
		statusWord[statusCountBits-1:0]       = doneCount;
		statusWord[statusBusyBit]             = busy;
	end

	//--------------------------------------------------------------------------
	// Control, divider and capture registers
	//--------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			enable    <= 1'b0;
			divider   <= divReset;
			keypadReg <= '0;
			doneCount <= '0;
		end
		else
		begin
			if (writeHit)
			begin
				case (writeAdrs[regOffBits-1:0])
					regCtrl: enable  <= writeData[0];
					regDiv:  divider <= writeData[divBits-1:0];
					default: ;	// Read-only or unmapped
				endcase
			end
			if (seqDone)
			begin
				keypadReg <= keyWord;
				doneCount <= doneCount + 1'b1;	// Wraps at 255
			end
		end
	end

	//--------------------------------------------------------------------------
	// Readback, one cycle after the strobe
	//--------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
			readValid <= 1'b0;
		else
			readValid <= readHit;	// Misses stay silent
	end

	always_ff @(posedge sysClk)
	begin
		if (readHit)
		begin
			case (readAdrs[regOffBits-1:0])
				regCtrl:   readData <= busDataBits'(enable);
				regDiv:    readData <= busDataBits'(divider);
				regKeypad: readData <= busDataBits'(keypadReg);
				regStatus: readData <= statusWord;
				default:   readData <= '0;	// Hole in the map
			endcase
		end
	end

endmodule

// ==== i2cPkg.sv ====
// I2C protocol constants for the keypad poller
// Used by the sequencer, the bit engine and the keypad model

package i2cPkg;

	//--------------------------------------------------------------------------
	// Widths
	//--------------------------------------------------------------------------
	localparam int divBits = 16;	// Quarter period divider
	localparam int keyBits = 16;	// Two data bytes
	localparam int cmdBits = 2;

	// Divider after reset
	localparam logic [divBits-1:0] divReset = 16'd4;

	//--------------------------------------------------------------------------
	// Target device
	//--------------------------------------------------------------------------
	localparam logic [6:0] keypadDevAdrs = 7'h20;
	localparam logic [7:0] adrsRdByte    = {keypadDevAdrs, 1'b1};	// R/W bit set

	//--------------------------------------------------------------------------
	// Bit engine commands
	//--------------------------------------------------------------------------
	localparam logic [cmdBits-1:0] cmdStart = 2'd0;
	localparam logic [cmdBits-1:0] cmdStop  = 2'd1;
	localparam logic [cmdBits-1:0] cmdWrite = 2'd2;	// Also master ACK/NACK
	localparam logic [cmdBits-1:0] cmdRead  = 2'd3;	// SDA released, sampled

endpackage

// ==== i2cSequencer.sv ====
// Transaction stage. While enabled, runs START, address, two read bytes and
// STOP as a series of bit commands and hands back the assembled key word
`timescale 1ns/100ps

module i2cSequencer (
	input  logic                       sysClk,
	input  logic                       rstN,
	input  logic                       enable,
	input  logic                       bitDone,
	input  logic                       bitRead,
	output logic                       bitStart,
	output logic [i2cPkg::cmdBits-1:0] bitCmd,
	output logic                       bitWrite,
	output logic [i2cPkg::keyBits-1:0] keyWord,
	output logic                       seqDone,
	output logic                       busy
);
	import i2cPkg::*;

	typedef enum logic [3:0] {
		sIdle,
		sStart,
		sAdrs,
		sAdrsAck,	// Target ACK, result ignored
		sHigh,
		sHighAck,	// Master ACK
		sLow,
		sLowNack,	// Master NACK ends the read
		sStop
	} stateT;

	stateT              state;
	stateT              nxtState;
	logic [2:0]         bitCnt;	// Bits left in the byte
	logic [2:0]         nxtCnt;
	logic               issue;
	logic [cmdBits-1:0] nxtCmd;
	logic               nxtWrite;
	logic               finish;
	logic [keyBits-1:0] shiftReg;

	assign busy = (state != sIdle);

	//--------------------------------------------------------------------------
	// Next command, decided on each bitDone
	//--------------------------------------------------------------------------
	always_comb
	begin
		nxtState = state;
		nxtCnt   = bitCnt;
		issue    = 1'b0;
		nxtCmd   = bitCmd;
		nxtWrite = bitWrite;
		finish   = 1'b0;
		if (state == sIdle)
		begin
			if (enable)
			begin
				nxtState = sStart;
				issue    = 1'b1;
				nxtCmd   = cmdStart;
				nxtWrite = 1'b1;
			end
		end
		else if (bitDone)
		begin
			issue    = 1'b1;
			nxtCmd   = cmdRead;	// Most slots read
			nxtWrite = 1'b1;
			case (state)
				sStart:
				begin
					nxtState = sAdrs;
					nxtCnt   = 3'd7;
					nxtCmd   = cmdWrite;
					nxtWrite = adrsRdByte[7];	// MSB first
				end
				sAdrs:
				begin
					if (bitCnt == 3'd0)
						nxtState = sAdrsAck;
					else
					begin
						nxtCnt   = bitCnt - 3'd1;
						nxtCmd   = cmdWrite;
						nxtWrite = adrsRdByte[bitCnt - 3'd1];
					end
				end
				sAdrsAck, sHighAck:
				begin
					nxtState = (state == sAdrsAck) ? sHigh : sLow;
					nxtCnt   = 3'd7;
				end
				sHigh, sLow:
				begin
					if (bitCnt == 3'd0)
					begin
						nxtState = (state == sHigh) ? sHighAck : sLowNack;
						nxtCmd   = cmdWrite;
						nxtWrite = (state == sLow);	// ACK low, NACK high
					end
					else
						nxtCnt = bitCnt - 3'd1;
				end
				sLowNack:
				begin
					nxtState = sStop;
					nxtCmd   = cmdStop;
				end
				default:	// STOP done
				begin
					finish = 1'b1;
					if (enable)
					begin
						nxtState = sStart;	// Poll again at once
						nxtCmd   = cmdStart;
					end
					else
					begin
						nxtState = sIdle;
						issue    = 1'b0;
					end
				end
			endcase
		end
	end

	//--------------------------------------------------------------------------
	// State and command registers
	//--------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state    <= sIdle;
			bitCnt   <= 3'd0;
			bitStart <= 1'b0;
			bitCmd   <= cmdStart;
			bitWrite <= 1'b1;
			seqDone  <= 1'b0;
			keyWord  <= '0;
		end
		else
		begin
			state    <= nxtState;
			bitCnt   <= nxtCnt;
			bitStart <= issue;
			seqDone  <= finish;
			if (issue)
			begin
				bitCmd   <= nxtCmd;
				bitWrite <= nxtWrite;
			end
			if (finish)
				keyWord <= shiftReg;	// Held until the next STOP
		end
	end

	// Data bits in, high byte first
	always_ff @(posedge sysClk)
	begin
		if (bitDone && (state == sHigh || state == sLow))
			shiftReg <= {shiftReg[keyBits-2:0], bitRead};
	end

endmodule

// ==== i2cTb.sv ====
// Testbench for the keypad I2C block with a keypad expander model on the pins
// Checks register access, polling results, drain on disable and idle pins
`timescale 1ns/100ps

module i2cTb;
	import busMapPkg::*;
	import i2cPkg::*;

	localparam int tbDiv      = 3;
	localparam int txnCycles  = 29 * 4 * (tbDiv + 1) + 29 * 4;	// With sequencing overhead
	localparam int cycleLimit = 6 * txnCycles + 2000;

	logic                   sysClk;
	logic                   rstN;
	logic                   writeEnable;
	logic [busAdrsBits-1:0] writeAdrs;
	logic [busDataBits-1:0] writeData;
	logic                   readEnable;
	logic [busAdrsBits-1:0] readAdrs;
	logic [busDataBits-1:0] readData;
	logic                   readValid;
	logic                   scl;
	wire                    sda;
	logic [keyBits-1:0]     modelKey;
	logic [7:0]             lastAdrs;
	logic [15:0]            adrsCount;
	logic [15:0]            adrsChecked = '0;
	logic                   pinsIdle    = 1'b0;	// Bus must rest high
	int                     cycles      = 0;
	logic [31:0]            lcgState;

	pullup (sda);	// Open-drain bus pull-up

	i2cBlock i2cBlock_inst (
		.sysClk      (sysClk),
		.rstN        (rstN),
		.writeEnable (writeEnable),
		.writeAdrs   (writeAdrs),
		.writeData   (writeData),
		.readEnable  (readEnable),
		.readAdrs    (readAdrs),
		.readData    (readData),
		.readValid   (readValid),
		.scl         (scl),
		.sda         (sda)
	);

	keypadModel keypadModel_inst (
		.scl       (scl),
		.sda       (sda),
		.keyWord   (modelKey),
		.lastAdrs  (lastAdrs),
		.adrsCount (adrsCount)
	);

	initial
	begin
		sysClk = 1'b0;
		forever
			#4 sysClk = ~sysClk;
	end

	//--------------------------------------------------------------------------
	// Helpers
	//--------------------------------------------------------------------------
	task automatic failNow();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic expectEq(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("MISMATCH at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
			failNow();
		end
	endtask

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic writeReg(input logic [regOffBits-1:0] off, input logic [31:0] data);
		@(posedge sysClk);
		#1;
		writeEnable = 1'b1;
		writeAdrs   = blockBase | 32'(off);
		writeData   = data;
		@(posedge sysClk);
		#1;
		writeEnable = 1'b0;
	endtask

	// Read strobe, then readValid one cycle later for a hit, never for a miss
	task automatic readAt(input logic [31:0] adrs, input logic hit, output logic [31:0] data);
		@(posedge sysClk);
		#1;
		readEnable = 1'b1;
		readAdrs   = adrs;
		@(posedge sysClk);
		#1;
		readEnable = 1'b0;
		expectEq("readValid", 32'(readValid), 32'(hit));
		data = readData;
		@(posedge sysClk);
		#1;
		expectEq("readValid", 32'(readValid), 32'd0);	// Single pulse
	endtask

	task automatic readReg(input logic [regOffBits-1:0] off, output logic [31:0] data);
		readAt(blockBase | 32'(off), 1'b1, data);
	endtask

	// Polls status until the count moves, which must be a step of one
	task automatic waitNextCount(input logic [7:0] prev, output logic [7:0] next);
		logic [31:0] data;
		data = 32'(prev);
		while (data[7:0] == prev)
			readReg(regStatus, data);
		next = data[7:0];
		expectEq("statusCount", 32'(next), 32'(prev + 8'd1));
	endtask

	//--------------------------------------------------------------------------
	// Timeout, idle pins and address byte seen by the model
	//--------------------------------------------------------------------------
	always @(posedge sysClk)
	begin
		cycles <= cycles + 1;
		assert (cycles < cycleLimit)
		else
		begin
			$display("TIMEOUT: no result after %0d clock cycles", cycleLimit);
			failNow();
		end
		if (pinsIdle)
		begin
			expectEq("scl", 32'(scl), 32'd1);
			expectEq("sda", 32'(sda), 32'd1);
		end
		if (adrsCount != adrsChecked)
		begin
			adrsChecked <= adrsCount;
			expectEq("modelAdrsByte", 32'(lastAdrs), 32'({keypadDevAdrs, 1'b1}));
		end
	end

	//--------------------------------------------------------------------------
	// Stimulus
	//--------------------------------------------------------------------------
	initial
	begin
		logic [31:0]        data;
		logic [31:0]        rnd;
		logic [7:0]         count;
		logic [7:0]         nextCount;
		logic [7:0]         drainStart;
		logic [7:0]         rise;
		logic [keyBits-1:0] newKey;
		lcgState    = 32'hee8fdf97;
		rstN        = 1'b0;
		writeEnable = 1'b0;
		writeAdrs   = '0;
		writeData   = '0;
		readEnable  = 1'b0;
		readAdrs    = '0;
		modelKey    = '0;
		repeat (5) @(posedge sysClk);
		#1;
		rstN     = 1'b1;
		pinsIdle = 1'b1;

		// Reset values
		readReg(regCtrl, data);
		expectEq("ctrl", data, 32'd0);
		readReg(regDiv, data);
		expectEq("divider", data, 32'(divReset));
		readReg(regKeypad, data);
		expectEq("keypad", data, 32'd0);
		readReg(regStatus, data);
		expectEq("status", data, 32'd0);

		// Divider readback and reads that miss the block
		writeReg(regDiv, 32'(tbDiv));
		readReg(regDiv, data);
		expectEq("divider", data, 32'(tbDiv));
		readAt(32'h0000_0800 | 32'(regDiv), 1'b0, data);
		readAt(~blockBase, 1'b0, data);

		// First poll returns the model's word
		rnd      = nextRand();
		modelKey = rnd[31:16];
		pinsIdle = 1'b0;
		writeReg(regCtrl, 32'd1);
		waitNextCount(8'd0, count);
		readReg(regKeypad, data);
		expectEq("keypad", data, 32'(modelKey));

		// New word shows up by the second completion
		rnd    = nextRand();
		newKey = rnd[31:16];
		if (newKey == modelKey)
			newKey = ~newKey;
		modelKey = newKey;
		waitNextCount(count, nextCount);
		waitNextCount(nextCount, count);
		readReg(regKeypad, data);
		expectEq("keypad", data, 32'(newKey));

		// Disable, current transaction drains
		writeReg(regCtrl, 32'd0);
		readReg(regStatus, data);
		drainStart = data[7:0];
		data[statusBusyBit] = 1'b1;
		while (data[statusBusyBit])
			readReg(regStatus, data);
		readReg(regStatus, data);	// Count settles a cycle after busy drops
		count = data[7:0];
		rise  = count - drainStart;
		assert (rise <= 8'd1)
		else
		begin
			$display("MISMATCH at %0t ns: statusCount rise expected at most 0x1, got 0x%0h",
				$time, rise);
			failNow();
		end
		pinsIdle = 1'b1;
		repeat (2 * txnCycles) @(posedge sysClk);
		readReg(regStatus, data);
		expectEq("status", data, 32'(count));	// Busy clear, count frozen
		readReg(regKeypad, data);
		expectEq("keypad", data, 32'(newKey));

		$display("Test passed");
		$finish;
	end

endmodule

// ==== keypadModel.sv ====
// Keypad port expander model for the testbench. Acts as an I2C target,
// acknowledges its address and returns a 16-bit key word MSB first
`timescale 1ns/100ps

module keypadModel (
	input  logic                       scl,
	inout  wire                        sda,
	input  logic [i2cPkg::keyBits-1:0] keyWord,	// Sampled at each START
	output logic [7:0]                 lastAdrs,
	output logic [15:0]                adrsCount	// Address bytes received
);
	import i2cPkg::*;

	localparam int idleSlot = 99;	// Parked outside a transaction

	logic               pullLow   = 1'b0;	// 1 drives SDA low
	logic               sclPrev   = 1'b1;
	logic               sdaPrev   = 1'b1;
	int                 edgeCnt   = idleSlot;	// SCL rises since START
	logic [7:0]         adrsShift = '0;
	logic [7:0]         adrsReg   = '0;
	logic [15:0]        adrsCnt   = '0;
	logic [keyBits-1:0] shadowKey = '0;

	assign sda       = pullLow ? 1'b0 : 1'bz;	// Open drain
	assign lastAdrs  = adrsReg;
	assign adrsCount = adrsCnt;

	// Pull for the bit in a given SCL slot
	// Slot 9 is the address ACK, 18 and 27 belong to the master
	function automatic logic slotLow(input int slot, input logic [keyBits-1:0] key);
		if (slot == 9)
			return 1'b1;
		if (slot >= 10 && slot <= 17)
			return !key[25 - slot];	// High byte
		if (slot >= 19 && slot <= 26)
			return !key[26 - slot];	// Low byte
		return 1'b0;
	endfunction

	//--------------------------------------------------------------------------
	// Bus watcher, one event at a time
	//--------------------------------------------------------------------------
	always @(scl or sda)
	begin
		if (sclPrev && scl && sdaPrev && !sda)
		begin
			edgeCnt   = 0;	// START
			shadowKey = keyWord;
			pullLow   = 1'b0;
		end
		else if (sclPrev && scl && !sdaPrev && sda)
		begin
			edgeCnt = idleSlot;	// STOP
			pullLow = 1'b0;
		end
		else if (!sclPrev && scl && edgeCnt < idleSlot)
		begin
			edgeCnt = edgeCnt + 1;
			if (edgeCnt <= 8)
				adrsShift = {adrsShift[6:0], sda};	// Address in, MSB first
			if (edgeCnt == 8)
			begin
				adrsReg = adrsShift;
				adrsCnt = adrsCnt + 16'd1;
			end
		end
		else if (sclPrev && !scl)
			pullLow = slotLow(edgeCnt + 1, shadowKey);	// Next bit while SCL low
		sclPrev = scl;
		sdaPrev = sda;
	end

endmodule

// ==== sim.f ====
busMapPkg.sv
i2cPkg.sv
i2cCsr.sv
i2cSequencer.sv
i2cBitEngine.sv
i2cBlock.sv
keypadModel.sv
i2cTb.sv
